//--- verilog.f
+incdir+sim
logic/aes_pkg.sv
logic/aes_round_counter.sv
logic/aes_ctrl.sv
logic/aes_engine.sv
logic/aes_streamer.sv
logic/aes_top.sv
sim/tb_aes_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the AES testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_aes_top -o sim_aes
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/sim_aes)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

//--- sim/aes_model.svh
// Reference AES-128 encryption for the testbench; call build_sbox once before encrypt_block
`ifndef AES_MODEL_SVH
`define AES_MODEL_SVH

logic [7:0] sbox_tbl [0:255];

// Carry-less product then long division by the AES polynomial
function automatic logic [7:0] poly_mul(input logic [7:0] a, input logic [7:0] b);
    logic [14:0] prod;
    prod = '0;
    for (int i = 0; i < 8; i++) begin
        if (b[i]) begin
            prod = prod ^ ({7'b0, a} << i);
        end
    end
    for (int i = 14; i >= 8; i--) begin
        if (prod[i]) begin
            prod = prod ^ (15'h11b << (i - 8));
        end
    end
    return prod[7:0];
endfunction

task automatic build_sbox();
    logic [7:0] inv;
    logic [7:0] c;
    c = 8'h63;
    for (int x = 0; x < 256; x++) begin
        inv = 8'h00;
        // Brute-force search for the inverse
        for (int y = 1; y < 256; y++) begin
            if (poly_mul(8'(x), 8'(y)) == 8'h01) begin
                inv = 8'(y);
            end
        end
        for (int i = 0; i < 8; i++) begin
            sbox_tbl[8'(x)][i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8]
                               ^ inv[(i + 6) % 8] ^ inv[(i + 7) % 8] ^ c[i];
        end
    end
endtask

function automatic logic [127:0] encrypt_block(input logic [127:0] key, input logic [127:0] pt);
    logic [7:0]   w [0:175];
    logic [7:0]   s [0:15];
    logic [7:0]   t [0:15];
    logic [7:0]   tmp [0:3];
    logic [7:0]   col [0:3];
    logic [7:0]   rc;
    logic [127:0] ct;
    rc = 8'h01;
    for (int i = 0; i < 16; i++) begin
        w[i] = key[127 - 8 * i -: 8];
        s[i] = pt[127 - 8 * i -: 8] ^ w[i];
    end
    // Whole key schedule of 176 bytes up front
    for (int i = 16; i < 176; i += 4) begin
        for (int j = 0; j < 4; j++) begin
            tmp[j] = w[i - 4 + j];
        end
        if (i % 16 == 0) begin
            tmp[0] = sbox_tbl[w[i - 3]] ^ rc;
            tmp[1] = sbox_tbl[w[i - 2]];
            tmp[2] = sbox_tbl[w[i - 1]];
            tmp[3] = sbox_tbl[w[i - 4]];
            rc = poly_mul(rc, 8'h02);
        end
        for (int j = 0; j < 4; j++) begin
            w[i + j] = w[i - 16 + j] ^ tmp[j];
        end
    end
    for (int r = 1; r <= 10; r++) begin
        // SubBytes and ShiftRows in one pass
        for (int i = 0; i < 16; i++) begin
            t[i] = sbox_tbl[s[(4 * (i / 4 + i % 4) + i % 4) % 16]];
        end
        if (r < 10) begin
            for (int c = 0; c < 4; c++) begin
                for (int j = 0; j < 4; j++) begin
                    col[j] = t[4 * c + j];
                end
                t[4 * c]     = poly_mul(col[0], 8'h02) ^ poly_mul(col[1], 8'h03) ^ col[2] ^ col[3];
                t[4 * c + 1] = col[0] ^ poly_mul(col[1], 8'h02) ^ poly_mul(col[2], 8'h03) ^ col[3];
                t[4 * c + 2] = col[0] ^ col[1] ^ poly_mul(col[2], 8'h02) ^ poly_mul(col[3], 8'h03);
                t[4 * c + 3] = poly_mul(col[0], 8'h03) ^ col[1] ^ col[2] ^ poly_mul(col[3], 8'h02);
            end
        end
        for (int i = 0; i < 16; i++) begin
            s[i] = t[i] ^ w[16 * r + i];
        end
    end
    for (int i = 0; i < 16; i++) begin
        ct[127 - 8 * i -: 8] = s[i];
    end
    return ct;
endfunction

`endif

//--- sim/tb_aes_top.sv
// Self-checking testbench for aes_top; random keys, input gaps and output stalls from a fixed seed
module tb_aes_top;

    `include "aes_model.svh"

    localparam int           N_RANDOM   = 30;
    localparam int           MAX_CYCLES = 4000;
    localparam logic [127:0] KAT_CT     = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    logic         clk;
    logic         reset;
    logic         key_valid;
    logic         key_ready;
    logic [127:0] key;
    logic         in_valid;
    logic         in_ready;
    logic [31:0]  in_data;
    logic         out_valid;
    logic         out_ready = 1'b1;
    logic [31:0]  out_data;
    logic         evt;

    integer       seed = 32'h7205;
    int           cycle = 0;
    int           errors = 0;
    int           out_errors = 0;
    int           sent = 0;
    int           words_out = 0;
    int           evt_count = 0;
    int           t_last_in = 0;
    int           t_first_out = -1;
    logic         rand_ready = 1'b0;
    logic         next_ready = 1'b1;
    logic [127:0] cur_key = '0;
    logic [31:0]  exp_word;
    logic [31:0]  exp_q [$];
    string        test_name = "reset_state";

    aes_top u_dut (
        .clk_i       ( clk       ),
        .reset_i     ( reset     ),
        .key_valid_i ( key_valid ),
        .key_ready_o ( key_ready ),
        .key_i       ( key       ),
        .in_valid_i  ( in_valid  ),
        .in_ready_o  ( in_ready  ),
        .in_data_i   ( in_data   ),
        .out_valid_o ( out_valid ),
        .out_ready_i ( out_ready ),
        .out_data_o  ( out_data  ),
        .evt_o       ( evt       )
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    initial begin
        wait (cycle >= MAX_CYCLES);
        $display("Timeout after %0d cycles, the run hung", cycle);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // Output stalls drawn at the falling edge and applied after the next rising edge
    always @(negedge clk) begin
        if (rand_ready) begin
            next_ready = ($random(seed) & 3) == 0;
        end else begin
            next_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        #2 out_ready = next_ready;
    end

    always @(negedge clk) begin
        if (!reset && evt) begin
            evt_count = evt_count + 1;
        end
    end

    // Scoreboard checks words in order on each output transfer
    always @(negedge clk) begin
        if (!reset && out_valid) begin
            if (t_first_out < 0) begin
                t_first_out = cycle;
            end
            if (out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Output word %h arrived with no block outstanding", out_data);
                    out_errors = out_errors + 1;
                end else begin
                    exp_word = exp_q.pop_front();
                    if (out_data !== exp_word) begin
                        $display("[ERROR] %s: expected %h, actual %h",
                                 test_name, exp_word, out_data);
                        out_errors = out_errors + 1;
                    end
                end
                words_out = words_out + 1;
            end
        end
    end

    task automatic send_key(input logic [127:0] k);
        logic done;
        done      = 1'b0;
        key_valid = 1'b1;
        key       = k;
        while (!done) begin
            @(negedge clk);
            done = key_ready;
            @(posedge clk);
            #2;
        end
        key_valid = 1'b0;
        cur_key   = k;
    endtask

    task automatic send_word(input logic [31:0] w);
        logic done;
        done     = 1'b0;
        in_valid = 1'b1;
        in_data  = w;
        while (!done) begin
            @(negedge clk);
            done = in_ready;
            @(posedge clk);
            #2;
        end
        in_valid = 1'b0;
    endtask

    task automatic send_block(input logic [127:0] pt, input logic [127:0] expected,
                              input logic gaps);
        int gap;
        for (int i = 0; i < 4; i++) begin
            gap = gaps ? ($random(seed) & 3) : 0;
            repeat (gap) begin
                @(posedge clk);
                #2;
            end
            send_word(pt[127 - 32 * i -: 32]);
        end
        t_last_in = cycle;
        for (int i = 0; i < 4; i++) begin
            exp_q.push_back(expected[127 - 32 * i -: 32]);
        end
        sent = sent + 1;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        logic [127:0] k;
        logic [127:0] pt;
        logic [127:0] expd;
        reset     = 1'b1;
        key_valid = 1'b0;
        key       = '0;
        in_valid  = 1'b0;
        in_data   = '0;
        build_sbox();
        repeat (4) @(posedge clk);
        #2 reset = 1'b0;

        @(negedge clk);
        if (out_valid !== 1'b0 || evt !== 1'b0 || key_ready !== 1'b1 || in_ready !== 1'b1) begin
            $display("[ERROR] %s: expected out_valid/evt/key_ready/in_ready 0011, actual %b%b%b%b",
                     test_name, out_valid, evt, key_ready, in_ready);
            errors = errors + 1;
        end
        @(posedge clk);
        #2;

        // FIPS-197 appendix C.1 vector with no gaps and no stalls
        test_name = "known_answer";
        k    = 128'h000102030405060708090a0b0c0d0e0f;
        pt   = 128'h00112233445566778899aabbccddeeff;
        expd = encrypt_block(k, pt);
        if (expd !== KAT_CT) begin
            $display("[ERROR] model_check: expected %h, actual %h", KAT_CT, expd);
            errors = errors + 1;
        end
        send_key(k);
        send_block(pt, KAT_CT, 1'b0);
        drain();
        if (t_first_out - t_last_in != 13) begin
            $display("[ERROR] latency: expected 13, actual %0d", t_first_out - t_last_in);
            errors = errors + 1;
        end

        test_name  = "random_blocks";
        rand_ready = 1'b1;
        for (int b = 0; b < N_RANDOM; b++) begin
            if (b == 0 || ($random(seed) & 1) == 0) begin
                k = {$random(seed), $random(seed), $random(seed), $random(seed)};
                send_key(k);
            end
            pt = {$random(seed), $random(seed), $random(seed), $random(seed)};
            send_block(pt, encrypt_block(cur_key, pt), 1'b1);
        end
        drain();
        rand_ready = 1'b0;

        if (evt_count != sent || words_out != 4 * sent) begin
            $display("[ERROR] events: expected %0d, actual %0d events and %0d blocks out",
                     sent, evt_count, words_out / 4);
            errors = errors + 1;
        end

        errors = errors + out_errors;
        $display("Errors: %0d, blocks sent %0d, received %0d, events %0d",
                 errors, sent, words_out / 4, evt_count);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- logic/aes_top.sv
// AES-128 encryption over 32-bit valid/ready streams; 13 cycles from last input word to output
module aes_top import aes_pkg::*; (
    input  logic   clk_i,
    input  logic   reset_i,
    input  logic   key_valid_i,
    output logic   key_ready_o,
    input  block_t key_i,
    input  logic   in_valid_i,
    output logic   in_ready_o,
    input  word_t  in_data_i,
    output logic   out_valid_o,
    input  logic   out_ready_i,
    output word_t  out_data_o,
    output logic   evt_o
);

    logic       key_we;
    logic       block_valid;
    logic       block_take;
    logic       result_free;
    logic       result_write;
    logic       round_start;
    logic       round_last;
    round_idx_t round;
    block_t     block;
    block_t     cipher_state;

    aes_streamer u_streamer (
        .clk_i          ( clk_i        ),
        .reset_i        ( reset_i      ),
        .in_valid_i     ( in_valid_i   ),
        .in_ready_o     ( in_ready_o   ),
        .in_data_i      ( in_data_i    ),
        .block_valid_o  ( block_valid  ),
        .block_o        ( block        ),
        .block_take_i   ( block_take   ),
        .result_i       ( cipher_state ),
        .result_write_i ( result_write ),
        .result_free_o  ( result_free  ),
        .out_valid_o    ( out_valid_o  ),
        .out_ready_i    ( out_ready_i  ),
        .out_data_o     ( out_data_o   )
    );

    aes_ctrl u_ctrl (
        .clk_i          ( clk_i        ),
        .reset_i        ( reset_i      ),
        .key_valid_i    ( key_valid_i  ),
        .key_ready_o    ( key_ready_o  ),
        .key_we_o       ( key_we       ),
        .block_valid_i  ( block_valid  ),
        .block_take_o   ( block_take   ),
        .result_free_i  ( result_free  ),
        .result_write_o ( result_write ),
        .round_start_o  ( round_start  ),
        .round_last_i   ( round_last   ),
        .evt_o          ( evt_o        )
    );

    aes_round_counter u_round_counter (
        .clk_i   ( clk_i       ),
        .reset_i ( reset_i     ),
        .start_i ( round_start ),
        .round_o ( round       ),
        .last_o  ( round_last  )
    );

    // The block take also triggers the engine load
    aes_engine u_engine (
        .clk_i    ( clk_i        ),
        .key_we_i ( key_we       ),
        .key_i    ( key_i        ),
        .load_i   ( block_take   ),
        .block_i  ( block        ),
        .round_i  ( round        ),
        .last_i   ( round_last   ),
        .state_o  ( cipher_state )
    );

endmodule

//--- logic/aes_streamer.sv
// Word 0 is the most significant word of the block; the packer takes no word while full
module aes_streamer import aes_pkg::*; (
    input  logic   clk_i,
    input  logic   reset_i,
    input  logic   in_valid_i,
    output logic   in_ready_o,
    input  word_t  in_data_i,
    output logic   block_valid_o,
    output block_t block_o,
    input  logic   block_take_i,
    input  block_t result_i,
    input  logic   result_write_i,
    output logic   result_free_o,
    output logic   out_valid_o,
    input  logic   out_ready_i,
    output word_t  out_data_o
);

    logic [1:0] pack_cnt_q;
    logic       full_q;
    block_t     pack_q;

    logic [2:0] out_cnt_q;
    block_t     out_q;

    // Packer shifts words in from the low end
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pack_cnt_q <= '0;
            full_q     <= 1'b0;
        end else if (block_take_i) begin
            full_q <= 1'b0;
        end else if (in_valid_i && in_ready_o) begin
            pack_cnt_q <= pack_cnt_q + 2'd1;
            full_q     <= (pack_cnt_q == 2'd3);
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o) begin
            pack_q <= {pack_q[95:0], in_data_i};
        end
    end

    assign in_ready_o    = !full_q;
    assign block_valid_o = full_q;
    assign block_o       = pack_q;

    // Unpacker presents the top word and counts down what is left
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            out_cnt_q <= '0;
        end else if (result_write_i) begin
            out_cnt_q <= 3'd4;
        end else if (out_valid_o && out_ready_i) begin
            out_cnt_q <= out_cnt_q - 3'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (result_write_i) begin
            out_q <= result_i;
        end else if (out_valid_o && out_ready_i) begin
            out_q <= {out_q[95:0], 32'h0};
        end
    end

    assign out_valid_o   = (out_cnt_q != '0);
    assign out_data_o    = out_q[127:96];
    assign result_free_o = (out_cnt_q == '0);

    a_out_hold: assert property (
        @(posedge clk_i) disable iff (reset_i)
        (out_valid_o && !out_ready_i) |=> $stable(out_data_o)
    );

endmodule

//--- logic/aes_engine.sv
// Iterative AES-128 encryption at one round per cycle; state holds whenever round_i is 0
module aes_engine import aes_pkg::*; (
    input  logic       clk_i,
    input  logic       key_we_i,
    input  block_t     key_i,
    input  logic       load_i,
    input  block_t     block_i,
    input  round_idx_t round_i,
    input  logic       last_i,
    output block_t     state_o
);

    block_t key_q;
    block_t rk_q;
    block_t state_q;

    byte_t  sub_b [16];
    byte_t  shf_b [16];
    block_t shf_blk;
    block_t mix_blk;
    block_t round_out;

    word_t  rk_w [4];
    word_t  nk_w [4];
    word_t  temp_w;
    block_t next_rk;

    // Byte n sits at bits 127-8n, column n/4 and row n%4 as in FIPS-197
    always_comb begin
        for (int n = 0; n < 16; n++) begin
            sub_b[n] = sbox(state_q[127-8*n -: 8]);
        end
        // ShiftRows moves row r left by r columns
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                shf_b[4*c+r] = sub_b[4*((c+r)%4)+r];
            end
        end
        for (int n = 0; n < 16; n++) begin
            shf_blk[127-8*n -: 8] = shf_b[n];
        end
    end

    // MixColumns with the 2 3 1 1 circulant
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                mix_blk[127-8*(4*c+r) -: 8] = gf_mul(8'h02, shf_b[4*c+r])
                                            ^ gf_mul(8'h03, shf_b[4*c+(r+1)%4])
                                            ^ shf_b[4*c+(r+2)%4]
                                            ^ shf_b[4*c+(r+3)%4];
            end
        end
    end

    // Next round key derived on the fly from the current one
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rk_w[i] = rk_q[127-32*i -: 32];
        end
        // RotWord then SubWord plus the round constant in the top byte
        temp_w = {sbox(rk_w[3][23:16]), sbox(rk_w[3][15:8]),
                  sbox(rk_w[3][7:0]), sbox(rk_w[3][31:24])};
        temp_w = temp_w ^ {rcon_of(round_i), 24'h0};
        nk_w[0] = rk_w[0] ^ temp_w;
        nk_w[1] = rk_w[1] ^ nk_w[0];
        nk_w[2] = rk_w[2] ^ nk_w[1];
        nk_w[3] = rk_w[3] ^ nk_w[2];
        next_rk = {nk_w[0], nk_w[1], nk_w[2], nk_w[3]};
    end

    // Final round has no MixColumns
    assign round_out = (last_i ? shf_blk : mix_blk) ^ next_rk;

    always_ff @(posedge clk_i) begin
        if (key_we_i) begin
            key_q <= key_i;
        end
        if (load_i) begin
            // Initial AddRoundKey with the cipher key
            state_q <= block_i ^ key_q;
            rk_q    <= key_q;
        end else if (round_i != '0) begin
            state_q <= round_out;
            rk_q    <= next_rk;
        end
    end

    assign state_o = state_q;

endmodule

//--- logic/aes_ctrl.sv
// One block at a time; keys are accepted only in IDLE while no full block is waiting
module aes_ctrl import aes_pkg::*; (
    input  logic clk_i,
    input  logic reset_i,
    input  logic key_valid_i,
    output logic key_ready_o,
    output logic key_we_o,
    input  logic block_valid_i,
    output logic block_take_o,
    input  logic result_free_i,
    output logic result_write_o,
    output logic round_start_o,
    input  logic round_last_i,
    output logic evt_o
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (block_valid_i) begin
                    state_d = LOAD;
                end
            end
            LOAD:    state_d = ROUND;
            ROUND:   if (round_last_i) state_d = WRITE;
            WRITE:   if (result_free_i) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign key_ready_o    = (state_q == IDLE) && !block_valid_i;
    assign key_we_o       = key_valid_i && key_ready_o;
    assign block_take_o   = (state_q == LOAD);
    assign round_start_o  = (state_q == LOAD);
    assign result_write_o = (state_q == WRITE) && result_free_i;
    // One pulse per finished block even after a stall
    assign evt_o          = result_write_o;

    // Counter and FSM stay in step through the rounds
    a_last_in_round: assert property (
        @(posedge clk_i) disable iff (reset_i) round_last_i |-> (state_q == ROUND)
    );

endmodule

//--- logic/aes_round_counter.sv
// Counts rounds 1..10 after each start pulse and rests at 0 in between; a new start restarts it
module aes_round_counter import aes_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       start_i,
    output round_idx_t round_o,
    output logic       last_o
);

    round_idx_t round_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            round_q <= '0;
        end else if (start_i) begin
            round_q <= 4'd1;
        end else if (round_q == N_ROUNDS) begin
            // Back to rest so the engine holds its state
            round_q <= '0;
        end else if (round_q != '0) begin
            round_q <= round_q + 4'd1;
        end
    end

    assign round_o = round_q;
    assign last_o  = (round_q == N_ROUNDS);

    a_round_in_range: assert property (
        @(posedge clk_i) disable iff (reset_i) round_q <= N_ROUNDS
    );

endmodule

//--- logic/aes_pkg.sv
// AES-128 encryption only; the S-box is computed as x^254 plus affine map, no table ROM
package aes_pkg;

    typedef logic [31:0]  word_t;
    typedef logic [127:0] block_t;
    typedef logic [7:0]   byte_t;
    typedef logic [3:0]   round_idx_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        ROUND,
        WRITE
    } ctrl_state_t;

    localparam round_idx_t N_ROUNDS = 4'd10;

    // Shift-and-add multiply reduced by x^8 + x^4 + x^3 + x + 1
    function automatic byte_t gf_mul(byte_t a, byte_t b);
        byte_t acc;
        byte_t x;
        acc = '0;
        x   = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ x;
            end
            x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
        end
        return acc;
    endfunction

    function automatic byte_t sbox(byte_t x);
        byte_t p;
        byte_t inv;
        p   = x;
        inv = 8'h01;
        // Product of x^2 .. x^128 gives the inverse x^254 (zero stays zero)
        for (int i = 1; i < 8; i++) begin
            p   = gf_mul(p, p);
            inv = gf_mul(inv, p);
        end
        return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
                   ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    endfunction

    function automatic byte_t rcon_of(round_idx_t r);
        case (r)
            4'd1:    return 8'h01;
            4'd2:    return 8'h02;
            4'd3:    return 8'h04;
            4'd4:    return 8'h08;
            4'd5:    return 8'h10;
            4'd6:    return 8'h20;
            4'd7:    return 8'h40;
            4'd8:    return 8'h80;
            4'd9:    return 8'h1b;
            4'd10:   return 8'h36;
            default: return 8'h00;
        endcase
    endfunction

endpackage
